// ==== verification/tb_rename_recovery.sv ====
// Rename recovery testbench
`include "rename_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_rename_recovery import rename_pkg::*; ();

	// One stimulus row, either a dispatch or a backout
	// back_off counts back from the tail, 1 is the youngest entry
	typedef struct packed {
		logic is_backout;
		aregno_t areg;
		logic grp_start;
		rob_ndx_t back_off;
		rob_ndx_t exp_tail;
	} row_t;

	localparam int N_ROWS = 33;
	localparam int TIMEOUT_CYCLES = N_ROWS * (2 * `RENAME_ROB_ENTRIES + 8);

	logic clk;
	logic rst;
	logic disp_valid;
	aregno_t disp_areg;
	pregno_t disp_new_preg;
	logic disp_grp_start;
	logic backout_req;
	rob_ndx_t branch_ndx;
	aregno_t look_areg;
	pregno_t look_preg;
	rob_ndx_t tail;
	logic backout_ack;
	logic stall;

	row_t rows [N_ROWS];
	// Reference RAT and its copy after every dispatch, indexed by ROB slot
	pregno_t model_rat [`RENAME_AREGS];
	pregno_t snap [`RENAME_ROB_ENTRIES][`RENAME_AREGS];
	rob_ndx_t model_tail;
	logic [31:0] lcg_state;
	int cycle_count;

	rename_recovery_top rename_recovery_top_i (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_areg(disp_areg),
		.disp_new_preg(disp_new_preg),
		.disp_grp_start(disp_grp_start),
		.backout_req(backout_req),
		.branch_ndx(branch_ndx),
		.look_areg(look_areg),
		.look_preg(look_preg),
		.tail(tail),
		.backout_ack(backout_ack),
		.stall(stall)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ============================================================
	// Error handling and compare tasks
	// ============================================================

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_preg(input string name, input pregno_t got, input pregno_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_ndx(input string name, input rob_ndx_t got, input rob_ndx_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// The run can never outlast the budget given to each row
	always @(posedge clk) begin
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout after %0d cycles without finishing", cycle_count));
		else
			cycle_count <= cycle_count + 1;
	end

	// ============================================================
	// Stimulus helpers
	// ============================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic row_t disp_row(input aregno_t areg, input logic gs, input rob_ndx_t et);
		row_t r;
		r = '0;
		r.areg = areg;
		r.grp_start = gs;
		r.exp_tail = et;
		return r;
	endfunction

	function automatic row_t bo_row(input rob_ndx_t off, input rob_ndx_t et);
		row_t r;
		r = '0;
		r.is_backout = 1'b1;
		r.back_off = off;
		r.exp_tail = et;
		return r;
	endfunction

	// Walks the lookup port over every architectural register
	task automatic compare_whole_rat();
		for (int r = 0; r < `RENAME_AREGS; r++) begin
			@(posedge clk);
			look_areg <= aregno_t'(r);
			@(negedge clk);
			check_preg($sformatf("look_preg[%0d]", r), look_preg, model_rat[r]);
		end
	endtask

	task automatic dispatch_one(input aregno_t areg, input logic gs, input rob_ndx_t exp_tail);
		pregno_t preg;
		lcg_state = lcg_next(lcg_state);
		preg = pregno_t'(lcg_state[20:16]);
		@(posedge clk);
		disp_valid <= 1'b1;
		disp_areg <= areg;
		disp_new_preg <= preg;
		disp_grp_start <= gs;
		@(posedge clk);
		disp_valid <= 1'b0;
		disp_grp_start <= 1'b0;
		look_areg <= areg;
		// The model renames and remembers the table as it stands after this entry
		model_rat[areg] = preg;
		for (int r = 0; r < `RENAME_AREGS; r++)
			snap[model_tail][r] = model_rat[r];
		model_tail = rob_ndx_t'((model_tail + 1) % `RENAME_ROB_ENTRIES);
		@(negedge clk);
		check_preg("look_preg", look_preg, model_rat[areg]);
		check_ndx("model tail", model_tail, exp_tail);
		check_ndx("tail", tail, model_tail);
		check_flag("stall", stall, 1'b0);
	endtask

	// Full four-phase handshake with stall watched on every cycle
	task automatic run_backout(input rob_ndx_t back_off, input rob_ndx_t exp_tail);
		rob_ndx_t br;
		br = rob_ndx_t'((model_tail + `RENAME_ROB_ENTRIES - back_off) % `RENAME_ROB_ENTRIES);
		@(posedge clk);
		backout_req <= 1'b1;
		branch_ndx <= br;
		@(negedge clk);
		while (!backout_ack) begin
			check_flag("stall", stall, 1'b1);
			@(negedge clk);
		end
		check_flag("stall", stall, 1'b1);
		// Everything younger than the branch is gone
		for (int r = 0; r < `RENAME_AREGS; r++)
			model_rat[r] = snap[br][r];
		model_tail = rob_ndx_t'((br + 1) % `RENAME_ROB_ENTRIES);
		check_ndx("model tail", model_tail, exp_tail);
		check_ndx("tail", tail, model_tail);
		// Acknowledge stays up while the request is held, so the RAT is read now
		compare_whole_rat();
		check_flag("backout_ack", backout_ack, 1'b1);
		@(posedge clk);
		backout_req <= 1'b0;
		@(negedge clk);
		while (backout_ack) begin
			check_flag("stall", stall, 1'b1);
			@(negedge clk);
		end
		check_flag("stall", stall, 1'b0);
		check_ndx("tail", tail, model_tail);
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic build_table();
		rows[0] = disp_row(3'd1, 1'b1, 4'd1);
		rows[1] = disp_row(3'd2, 1'b0, 4'd2);
		rows[2] = disp_row(3'd1, 1'b0, 4'd3);
		rows[3] = disp_row(3'd3, 1'b1, 4'd4);
		// Branch is the youngest entry and alone in its group
		rows[4] = bo_row(4'd1, 4'd4);
		rows[5] = disp_row(3'd4, 1'b1, 4'd5);
		rows[6] = disp_row(3'd1, 1'b0, 4'd6);
		rows[7] = disp_row(3'd5, 1'b0, 4'd7);
		rows[8] = disp_row(3'd4, 1'b0, 4'd8);
		rows[9] = disp_row(3'd2, 1'b1, 4'd9);
		rows[10] = disp_row(3'd1, 1'b0, 4'd10);
		rows[11] = disp_row(3'd6, 1'b1, 4'd11);
		rows[12] = disp_row(3'd5, 1'b0, 4'd12);
		rows[13] = disp_row(3'd7, 1'b0, 4'd13);
		// Branch in slot 6 and third of its group, with younger entries in three groups
		rows[14] = bo_row(4'd7, 4'd7);
		rows[15] = disp_row(3'd0, 1'b1, 4'd8);
		rows[16] = disp_row(3'd3, 1'b0, 4'd9);
		rows[17] = disp_row(3'd2, 1'b1, 4'd10);
		rows[18] = disp_row(3'd1, 1'b0, 4'd11);
		rows[19] = disp_row(3'd6, 1'b0, 4'd12);
		rows[20] = disp_row(3'd7, 1'b1, 4'd13);
		rows[21] = disp_row(3'd4, 1'b0, 4'd14);
		// This group spans slots 14, 15, 0 and 1
		rows[22] = disp_row(3'd5, 1'b1, 4'd15);
		rows[23] = disp_row(3'd0, 1'b0, 4'd0);
		rows[24] = disp_row(3'd3, 1'b0, 4'd1);
		rows[25] = disp_row(3'd1, 1'b0, 4'd2);
		rows[26] = disp_row(3'd2, 1'b1, 4'd3);
		rows[27] = disp_row(3'd6, 1'b0, 4'd4);
		// Branch in slot 0, the forward walk wraps from slot 14
		rows[28] = bo_row(4'd4, 4'd1);
		rows[29] = disp_row(3'd5, 1'b1, 4'd2);
		rows[30] = disp_row(3'd7, 1'b0, 4'd3);
		rows[31] = bo_row(4'd2, 4'd2);
		rows[32] = disp_row(3'd4, 1'b1, 4'd3);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_areg = '0;
		disp_new_preg = '0;
		disp_grp_start = 1'b0;
		backout_req = 1'b0;
		branch_ndx = '0;
		look_areg = '0;
		lcg_state = 32'h37ac;
		cycle_count = 0;
		model_tail = '0;
		for (int r = 0; r < `RENAME_AREGS; r++)
			model_rat[r] = pregno_t'(r);
		build_table();

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_ndx("tail", tail, '0);
		check_flag("stall", stall, 1'b0);
		check_flag("backout_ack", backout_ack, 1'b0);
		// Identity mapping out of reset
		compare_whole_rat();

		for (int i = 0; i < N_ROWS; i++) begin
			if (rows[i].is_backout)
				run_backout(rows[i].back_off, rows[i].exp_tail);
			else
				dispatch_one(rows[i].areg, rows[i].grp_start, rows[i].exp_tail);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/rob_store.sv
verilog/rat_table.sv
verilog/rob_walk_counter.sv
verilog/backout_fsm.sv
verilog/rename_recovery_top.sv
verification/tb_rename_recovery.sv

// ==== verilog/backout_fsm.sv ====
// Branch backout state machine
`timescale 1ns/1ps
`default_nettype none

module backout_fsm import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire backout_req,
	input wire rob_ndx_t branch_ndx,
	input wire rob_ndx_t youngest_ndx,
	input wire rob_ndx_t grp_first_ndx,
	input wire rob_entry_t walk_entry,
	input wire seqno_t branch_sn,
	input wire rob_ndx_t cnt_ndx,
	input wire cnt_at_target,
	output logic backout_ack,
	output logic stall,
	output logic cnt_load,
	output rob_ndx_t cnt_load_ndx,
	output logic cnt_step,
	output walk_dir_t cnt_dir,
	output rob_ndx_t cnt_target,
	output logic bo_wr,
	output aregno_t bo_areg,
	output pregno_t bo_preg,
	output logic flush,
	output rob_ndx_t flush_ndx
);

	typedef enum logic [2:0] {
		idle,
		walk_back,
		walk_fwd,
		done,
		wait_drop
	} state_t;

	state_t state;
	state_t state_nxt;
	// Branch index captured when the request is taken
	rob_ndx_t branch_q;
	// The backward walk ends on the entry just after the branch
	logic back_last;
	// Sequence distance of the walked entry past the branch
	seqno_t sn_dist;
	logic younger;

	assign back_last = (cnt_ndx == rob_inc(branch_q));

	// Sequence numbers wrap, so compare by the sign of the difference
	assign sn_dist = walk_entry.sn - branch_sn;
	assign younger = (sn_dist != '0) && !sn_dist[$bits(seqno_t)-1];

	// ============================================================
	// Walk sequencing
	// ============================================================

	always_comb begin
		state_nxt = state;
		cnt_load = 1'b0;
		cnt_load_ndx = grp_first_ndx;
		cnt_step = 1'b0;
		case (state)
			idle: begin
				// With nothing younger than the branch only the forward walk runs
				if (backout_req) begin
					cnt_load = 1'b1;
					if (youngest_ndx != branch_ndx) begin
						cnt_load_ndx = youngest_ndx;
						state_nxt = walk_back;
					end else begin
						state_nxt = walk_fwd;
					end
				end
			end
			walk_back: begin
				if (back_last) begin
					cnt_load = 1'b1;
					state_nxt = walk_fwd;
				end else begin
					cnt_step = 1'b1;
				end
			end
			walk_fwd: begin
				if (cnt_at_target)
					state_nxt = done;
				else
					cnt_step = 1'b1;
			end
			done: state_nxt = wait_drop;
			// Hold the acknowledge until the requester lets go
			wait_drop: begin
				if (!backout_req)
					state_nxt = idle;
			end
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			branch_q <= '0;
			bo_wr <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == idle && backout_req)
				branch_q <= branch_ndx;
			// Every walk step produces one table write a cycle later
			bo_wr <= (state == walk_back) || (state == walk_fwd);
		end
	end

	// ============================================================
	// Table write data
	// ============================================================

	// Younger entries give back their old mapping, the branch group
	// reapplies its new one
	always_ff @(posedge clk) begin
		bo_areg <= walk_entry.areg;
		bo_preg <= younger ? walk_entry.old_preg : walk_entry.new_preg;
	end

	assign cnt_dir = (state == walk_fwd) ? walk_up : walk_down;
	assign cnt_target = branch_q;

	// The flush cycle also carries the last table write
	assign flush = (state == done);
	assign flush_ndx = rob_inc(branch_q);

	assign backout_ack = (state == wait_drop);
	// Dispatch is held from the first sight of the request
	assign stall = backout_req | (state != idle);

	// Four-phase rule, the request stays up until the acknowledge is seen
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		$fell(backout_req) |-> backout_ack)
		else $error("backout_fsm: request dropped before acknowledge");

endmodule

`default_nettype wire

// ==== verilog/rat_table.sv ====
// Register alias table
`include "rename_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module rat_table import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire rn_wr,
	input wire aregno_t rn_areg,
	input wire pregno_t rn_preg,
	input wire bo_wr,
	input wire aregno_t bo_areg,
	input wire pregno_t bo_preg,
	input wire aregno_t look_areg,
	output pregno_t rn_old_preg,
	output pregno_t look_preg
);

	// Current physical register of each architectural register
	pregno_t rat_map [`RENAME_AREGS];

	// Reset gives the identity mapping
	// Rename and backout writes are mutually exclusive, see below
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `RENAME_AREGS; r++)
				rat_map[r] <= pregno_t'(r);
		end else if (rn_wr) begin
			rat_map[rn_areg] <= rn_preg;
		end else if (bo_wr) begin
			rat_map[bo_areg] <= bo_preg;
		end
	end

	// Dispatch sees the mapping it is about to replace
	assign rn_old_preg = rat_map[rn_areg];

	// Lookup port, valid in any cycle
	assign look_preg = rat_map[look_areg];

	// Dispatch is stalled for the whole backout, so the write ports never collide
	a_one_writer: assert property (@(posedge clk) disable iff (rst)
		!(rn_wr && bo_wr))
		else $error("rat_table: rename and backout write together");

endmodule

`default_nettype wire

// ==== verilog/rename_defines.svh ====
// Rename recovery sizing
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Number of reorder buffer entries, the index wraps at this count
`define RENAME_ROB_ENTRIES 16

// Architectural registers visible to software
`define RENAME_AREGS 8

// Physical registers behind the alias table
`define RENAME_PREGS 32

// Largest number of instructions that dispatch as one group
`define RENAME_GROUP_MAX 4

// Widths of the running dispatch counters
`define RENAME_SN_BITS 8
`define RENAME_GRP_BITS 4

`endif

// ==== verilog/rename_pkg.sv ====
// Rename recovery types
`include "rename_defines.svh"
`default_nettype none

package rename_pkg;

	// ============================================================
	// Index and register number types
	// ============================================================

	typedef logic [$clog2(`RENAME_ROB_ENTRIES)-1:0] rob_ndx_t;
	typedef logic [$clog2(`RENAME_AREGS)-1:0] aregno_t;
	typedef logic [$clog2(`RENAME_PREGS)-1:0] pregno_t;
	typedef logic [`RENAME_SN_BITS-1:0] seqno_t;
	typedef logic [`RENAME_GRP_BITS-1:0] grpno_t;

	// One renamed destination as recorded at dispatch
	// old_preg is the mapping that was replaced, new_preg the one installed
	typedef struct packed {
		seqno_t sn;
		grpno_t grp;
		aregno_t areg;
		pregno_t new_preg;
		pregno_t old_preg;
	} rob_entry_t;

	// Step direction of the walk counter
	typedef enum logic {
		walk_down,
		walk_up
	} walk_dir_t;

	// Next index around the ROB ring
	function automatic rob_ndx_t rob_inc(rob_ndx_t ndx);
		if (ndx == rob_ndx_t'(`RENAME_ROB_ENTRIES - 1))
			return '0;
		return ndx + 1'b1;
	endfunction

	// Previous index around the ROB ring
	function automatic rob_ndx_t rob_dec(rob_ndx_t ndx);
		if (ndx == '0)
			return rob_ndx_t'(`RENAME_ROB_ENTRIES - 1);
		return ndx - 1'b1;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/rename_recovery_top.sv ====
// Rename recovery top level
`timescale 1ns/1ps
`default_nettype none

module rename_recovery_top import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire disp_valid,
	input wire aregno_t disp_areg,
	input wire pregno_t disp_new_preg,
	input wire disp_grp_start,
	input wire backout_req,
	input wire rob_ndx_t branch_ndx,
	input wire aregno_t look_areg,
	output pregno_t look_preg,
	output rob_ndx_t tail,
	output logic backout_ack,
	output logic stall
);

	// Store and table
	pregno_t rn_old_preg;
	rob_entry_t walk_entry;
	seqno_t branch_sn;
	rob_ndx_t youngest_ndx;
	rob_ndx_t grp_first_ndx;

	// Walk counter
	logic cnt_load;
	rob_ndx_t cnt_load_ndx;
	logic cnt_step;
	walk_dir_t cnt_dir;
	rob_ndx_t cnt_target;
	rob_ndx_t cnt_ndx;
	logic cnt_at_target;

	// Backout writes and flush
	logic bo_wr;
	aregno_t bo_areg;
	pregno_t bo_preg;
	logic flush;
	rob_ndx_t flush_ndx;

	rob_store rob_store_i (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_areg(disp_areg),
		.disp_new_preg(disp_new_preg),
		.disp_grp_start(disp_grp_start),
		.rn_old_preg(rn_old_preg),
		.walk_ndx(cnt_ndx),
		.branch_ndx(branch_ndx),
		.flush(flush),
		.flush_ndx(flush_ndx),
		.walk_entry(walk_entry),
		.branch_sn(branch_sn),
		.youngest_ndx(youngest_ndx),
		.grp_first_ndx(grp_first_ndx),
		.tail(tail)
	);

	// Dispatch renames through the same port that supplies old_preg
	rat_table rat_table_i (
		.clk(clk),
		.rst(rst),
		.rn_wr(disp_valid),
		.rn_areg(disp_areg),
		.rn_preg(disp_new_preg),
		.bo_wr(bo_wr),
		.bo_areg(bo_areg),
		.bo_preg(bo_preg),
		.look_areg(look_areg),
		.rn_old_preg(rn_old_preg),
		.look_preg(look_preg)
	);

	rob_walk_counter rob_walk_counter_i (
		.clk(clk),
		.rst(rst),
		.cnt_load(cnt_load),
		.cnt_load_ndx(cnt_load_ndx),
		.cnt_step(cnt_step),
		.cnt_dir(cnt_dir),
		.cnt_target(cnt_target),
		.cnt_ndx(cnt_ndx),
		.cnt_at_target(cnt_at_target)
	);

	backout_fsm backout_fsm_i (
		.clk(clk),
		.rst(rst),
		.backout_req(backout_req),
		.branch_ndx(branch_ndx),
		.youngest_ndx(youngest_ndx),
		.grp_first_ndx(grp_first_ndx),
		.walk_entry(walk_entry),
		.branch_sn(branch_sn),
		.cnt_ndx(cnt_ndx),
		.cnt_at_target(cnt_at_target),
		.backout_ack(backout_ack),
		.stall(stall),
		.cnt_load(cnt_load),
		.cnt_load_ndx(cnt_load_ndx),
		.cnt_step(cnt_step),
		.cnt_dir(cnt_dir),
		.cnt_target(cnt_target),
		.bo_wr(bo_wr),
		.bo_areg(bo_areg),
		.bo_preg(bo_preg),
		.flush(flush),
		.flush_ndx(flush_ndx)
	);

endmodule

`default_nettype wire

// ==== verilog/rob_store.sv ====
// Reorder buffer entry store
`include "rename_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module rob_store import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire disp_valid,
	input wire aregno_t disp_areg,
	input wire pregno_t disp_new_preg,
	input wire disp_grp_start,
	input wire pregno_t rn_old_preg,
	input wire rob_ndx_t walk_ndx,
	input wire rob_ndx_t branch_ndx,
	input wire flush,
	input wire rob_ndx_t flush_ndx,
	output rob_entry_t walk_entry,
	output seqno_t branch_sn,
	output rob_ndx_t youngest_ndx,
	output rob_ndx_t grp_first_ndx,
	output rob_ndx_t tail
);

	// Entry array, written only at the tail
	rob_entry_t rob_mem [`RENAME_ROB_ENTRIES];

	// Running dispatch sequence number and current group number
	seqno_t sn_next;
	grpno_t grp_cur;
	// Entries already placed in the current group
	logic [$clog2(`RENAME_GROUP_MAX+1)-1:0] grp_len;
	// Set after reset or flush so that the next dispatch opens a group
	logic grp_pend;
	logic grp_open;
	grpno_t grp_disp;
	rob_entry_t disp_entry;
	// Scratch for the group start search
	rob_ndx_t grp_probe;
	logic grp_same;

	// ============================================================
	// Dispatch
	// ============================================================

	// A redirected fetch always begins a fresh group
	assign grp_open = disp_grp_start | grp_pend;
	assign grp_disp = grp_open ? grp_cur + 1'b1 : grp_cur;

	// The replaced mapping comes straight from the alias table read
	always_comb begin
		disp_entry.sn = sn_next;
		disp_entry.grp = grp_disp;
		disp_entry.areg = disp_areg;
		disp_entry.new_preg = disp_new_preg;
		disp_entry.old_preg = rn_old_preg;
	end

	always_ff @(posedge clk) begin
		if (disp_valid)
			rob_mem[tail] <= disp_entry;
	end

	// Tail and counters, a flush pulls the tail back behind the branch
	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
			sn_next <= '0;
			grp_cur <= '0;
			grp_len <= '0;
			grp_pend <= 1'b1;
		end else if (flush) begin
			tail <= flush_ndx;
			grp_pend <= 1'b1;
		end else if (disp_valid) begin
			tail <= rob_inc(tail);
			sn_next <= sn_next + 1'b1;
			grp_cur <= grp_disp;
			grp_len <= grp_open ? 1'b1 : grp_len + 1'b1;
			grp_pend <= 1'b0;
		end
	end

	// ============================================================
	// Read ports for the backout machine
	// ============================================================

	assign walk_entry = rob_mem[walk_ndx];
	assign branch_sn = rob_mem[branch_ndx].sn;
	assign youngest_ndx = rob_dec(tail);

	// Groups are contiguous, so walk down from the branch while the
	// group number still matches and remember the lowest match
	always_comb begin
		grp_first_ndx = branch_ndx;
		grp_probe = branch_ndx;
		grp_same = 1'b1;
		for (int d = 1; d < `RENAME_GROUP_MAX; d++) begin
			grp_probe = rob_dec(grp_probe);
			grp_same = grp_same & (rob_mem[grp_probe].grp == rob_mem[branch_ndx].grp);
			if (grp_same)
				grp_first_ndx = grp_probe;
		end
	end

	// The flush comes from the backout machine while dispatch is held off
	a_no_disp_on_flush: assert property (@(posedge clk) disable iff (rst)
		flush |-> !disp_valid)
		else $error("rob_store: dispatch during flush");

	// A group that keeps growing would break the group start search
	a_grp_max: assert property (@(posedge clk) disable iff (rst)
		disp_valid && !grp_open |-> grp_len < `RENAME_GROUP_MAX)
		else $error("rob_store: dispatch group too large");

endmodule

`default_nettype wire

// ==== verilog/rob_walk_counter.sv ====
// ROB walk index counter
`timescale 1ns/1ps
`default_nettype none

module rob_walk_counter import rename_pkg::*; (
	input wire clk,
	input wire rst,
	input wire cnt_load,
	input wire rob_ndx_t cnt_load_ndx,
	input wire cnt_step,
	input wire walk_dir_t cnt_dir,
	input wire rob_ndx_t cnt_target,
	output rob_ndx_t cnt_ndx,
	output logic cnt_at_target
);

	// Index of the entry being walked
	// A load wins over a step, though the two are never requested together
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_ndx <= '0;
		end else if (cnt_load) begin
			cnt_ndx <= cnt_load_ndx;
		end else if (cnt_step) begin
			if (cnt_dir == walk_up)
				cnt_ndx <= rob_inc(cnt_ndx);
			else
				cnt_ndx <= rob_dec(cnt_ndx);
		end
	end

	// The walk has reached the branch entry
	assign cnt_at_target = (cnt_ndx == cnt_target);

	// The state machine either starts a walk or advances it in one cycle
	a_load_xor_step: assert property (@(posedge clk) disable iff (rst)
		!(cnt_load && cnt_step))
		else $error("rob_walk_counter: load and step together");

endmodule

`default_nettype wire
